//--- lsu.f
lsu_pkg.sv
lsu_agu.sv
lsu_bypass.sv
lsu_region_cfg.sv
lsu_fault_check.sv
lsu_load_unit.sv
lsu_store_unit.sv
lsu_top.sv
tb_lsu_mem.sv
tb_lsu.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_lsu
FILELIST  := lsu.f
FLAGS     := --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

//--- tb_lsu.sv
`default_nettype none

module tb_lsu import lsu_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned WAIT_LIMIT = 400;

    logic        clk_i;
    logic        rst_ni;
    logic        lsu_valid_i;
    lsu_req_t    lsu_req_i;
    logic        lsu_ready_o;
    region_cfg_t cfg_i;
    mem_req_t    ld_mem_o;
    mem_rsp_t    ld_mem_i;
    mem_req_t    st_mem_o;
    mem_rsp_t    st_mem_i;
    logic        load_valid_o;
    lsu_result_t load_result_o;
    logic        store_valid_o;
    lsu_result_t store_result_o;
    logic        slow_mem;

    // reference model state
    logic [XLEN-1:0]          shadow [256];
    logic [XLEN-1:0]          sh_base;
    logic [XLEN-1:0]          sh_limit;
    lsu_result_t              ld_q [$];
    lsu_result_t              st_q [$];
    logic [TRANS_ID_BITS-1:0] next_id;
    int unsigned              ready_low_cycles = 0;

    lsu_top UUT (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .lsu_valid_i    (lsu_valid_i),
        .lsu_req_i      (lsu_req_i),
        .lsu_ready_o    (lsu_ready_o),
        .cfg_i          (cfg_i),
        .ld_mem_o       (ld_mem_o),
        .ld_mem_i       (ld_mem_i),
        .st_mem_o       (st_mem_o),
        .st_mem_i       (st_mem_i),
        .load_valid_o   (load_valid_o),
        .load_result_o  (load_result_o),
        .store_valid_o  (store_valid_o),
        .store_result_o (store_result_o)
    );

    tb_lsu_mem mem_model (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .slow_i   (slow_mem),
        .ld_req_i (ld_mem_o),
        .ld_rsp_o (ld_mem_i),
        .st_req_i (st_mem_o),
        .st_rsp_o (st_mem_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // --------------------------------------------------
    // error reporting and compare tasks
    // --------------------------------------------------
    task automatic report_failure(string line);
        $display("%s", line);
        $display("Checks failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_load_result(lsu_result_t got, lsu_result_t exp);
        if (got !== exp) begin
            report_failure($sformatf("FAILED at %0t: load_result_o got %h expected %h",
                                     $time, got, exp));
        end
    endtask

    task automatic check_store_result(lsu_result_t got, lsu_result_t exp);
        if (got !== exp) begin
            report_failure($sformatf("FAILED at %0t: store_result_o got %h expected %h",
                                     $time, got, exp));
        end
    endtask

    task automatic verify_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            report_failure($sformatf("FAILED at %0t: %s got %b expected %b",
                                     $time, name, got, exp));
        end
    endtask

    task automatic compare_mem_word(int idx, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("FAILED at %0t: mem[%0d] got %h expected %h",
                                     $time, idx, got, exp));
        end
    endtask

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    function automatic logic [XLEN-1:0] fill_word(logic [7:0] idx);
        return {idx ^ 8'ha5, ~idx, idx, idx + 8'h3c};
    endfunction

    function automatic int access_bytes(lsu_op_e op);
        case (op)
            LB, LBU, SB: return 1;
            LH, LHU, SH: return 2;
            default:     return 4;
        endcase
    endfunction

    // applies one request in program order and returns its expected result
    function automatic lsu_result_t model_access(lsu_op_e op, logic [XLEN-1:0] addr,
                                                 logic [XLEN-1:0] data,
                                                 logic [TRANS_ID_BITS-1:0] id);
        lsu_result_t     r;
        logic            is_ld;
        logic            mis;
        int              nbytes;
        logic [XLEN-1:0] lane;
        r          = '0;
        r.trans_id = id;
        is_ld      = op inside {LB, LBU, LH, LHU, LW};
        nbytes     = access_bytes(op);
        mis        = (nbytes == 2 && addr[0]) || (nbytes == 4 && addr[1:0] != 2'b00);
        if (addr < sh_base || addr > sh_limit) begin
            r.ex.valid = 1'b1;
            r.ex.cause = is_ld ? LD_ACCESS_FAULT : ST_ACCESS_FAULT;
            r.ex.tval  = addr;
        end else if (mis) begin
            r.ex.valid = 1'b1;
            r.ex.cause = is_ld ? LD_ADDR_MISALIGNED : ST_ADDR_MISALIGNED;
            r.ex.tval  = addr;
        end else if (is_ld) begin
            lane = shadow[addr[9:2]] >> (8 * int'(addr[1:0]));
            case (op)
                LB:      r.data = {{24{lane[7]}}, lane[7:0]};
                LBU:     r.data = {24'h0, lane[7:0]};
                LH:      r.data = {{16{lane[15]}}, lane[15:0]};
                LHU:     r.data = {16'h0, lane[15:0]};
                default: r.data = lane;
            endcase
        end else begin
            for (int b = 0; b < nbytes; b++) begin
                shadow[addr[9:2]][8 * (int'(addr[1:0]) + b) +: 8] = data[8*b +: 8];
            end
        end
        return r;
    endfunction

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    task automatic issue(lsu_op_e op, logic [XLEN-1:0] addr, logic [XLEN-1:0] data);
        lsu_req_t        req;
        logic [11:0]     imm12;
        logic [XLEN-1:0] imm;
        int              n;
        n = 0;
        // wait for an empty buffer
        @(negedge clk_i);
        while (!lsu_ready_o) begin
            @(negedge clk_i);
            n++;
            if (n > WAIT_LIMIT) report_failure("timeout waiting for lsu_ready_o to rise");
        end
        imm12         = 12'($urandom);
        imm           = {{20{imm12[11]}}, imm12};
        req.op        = op;
        req.operand_a = addr - imm;
        req.imm       = imm;
        req.operand_b = data;
        req.trans_id  = next_id;
        if (op inside {LB, LBU, LH, LHU, LW}) begin
            ld_q.push_back(model_access(op, addr, data, next_id));
        end else begin
            st_q.push_back(model_access(op, addr, data, next_id));
        end
        next_id = next_id + 1'b1;
        @(posedge clk_i);
        lsu_valid_i <= 1'b1;
        lsu_req_i   <= req;
        @(posedge clk_i);
        lsu_valid_i <= 1'b0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (ld_q.size() != 0 || st_q.size() != 0 || !lsu_ready_o) begin
            @(posedge clk_i);
            n++;
            if (n > WAIT_LIMIT) report_failure("timeout waiting for outstanding results");
        end
    endtask

    task automatic write_region(logic [XLEN-1:0] base, logic [XLEN-1:0] limit);
        drain();
        @(posedge clk_i);
        cfg_i <= '{we: 1'b1, sel: 1'b0, wdata: base};
        @(posedge clk_i);
        cfg_i <= '{we: 1'b1, sel: 1'b1, wdata: limit};
        @(posedge clk_i);
        cfg_i    <= '0;
        sh_base  = base;
        sh_limit = limit;
    endtask

    // stores a word, then reads every lane back with each load size
    task automatic run_lane_sweep();
        logic [XLEN-1:0] base;
        for (int k = 0; k < 8; k++) begin
            base = {22'h0, 8'($urandom), 2'b00};
            issue(SW, base, $urandom());
            for (int off = 0; off < 4; off++) begin
                issue(LB, base + XLEN'(off), '0);
                issue(LBU, base + XLEN'(off), '0);
            end
            for (int off = 0; off < 4; off += 2) begin
                issue(LH, base + XLEN'(off), '0);
                issue(LHU, base + XLEN'(off), '0);
            end
            issue(SB, base + 1, $urandom());
            issue(SH, base + 2, $urandom());
            issue(LW, base, '0);
        end
    endtask

    task automatic run_random(int count, logic mis_ok);
        lsu_op_e         op;
        logic [XLEN-1:0] addr;
        for (int i = 0; i < count; i++) begin
            op   = lsu_op_e'(3'($urandom_range(7)));
            addr = XLEN'($urandom_range(1023));
            if (!mis_ok && access_bytes(op) == 2) begin
                addr[0] = 1'b0;
            end
            if (!mis_ok && access_bytes(op) == 4) begin
                addr[1:0] = 2'b00;
            end
            issue(op, addr, $urandom());
        end
    endtask

    // result and memory port monitor
    always @(negedge clk_i) begin
        if (rst_ni) begin
            if (!lsu_ready_o) begin
                ready_low_cycles = ready_low_cycles + 1;
            end
            if (ld_mem_o.req) begin
                verify_flag("ld_mem_o.we", ld_mem_o.we, 1'b0);
            end
            if (st_mem_o.req) begin
                verify_flag("st_mem_o.we", st_mem_o.we, 1'b1);
            end
            if (load_valid_o) begin
                if (ld_q.size() == 0) report_failure("load result with no load outstanding");
                else check_load_result(load_result_o, ld_q.pop_front());
            end
            if (store_valid_o) begin
                if (st_q.size() == 0) report_failure("store result with no store outstanding");
                else check_store_result(store_result_o, st_q.pop_front());
            end
        end
    end

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        int unsigned     low_before;
        logic [XLEN-1:0] base;
        void'($urandom(32'h30bd));
        rst_ni      = 1'b0;
        lsu_valid_i = 1'b0;
        lsu_req_i   = '0;
        cfg_i       = '0;
        slow_mem    = 1'b0;
        sh_base     = '0;
        sh_limit    = '1;
        next_id     = '0;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = fill_word(8'(i));
        end
        repeat (16) @(posedge clk_i);
        rst_ni <= 1'b1;

        // idle state out of reset
        @(negedge clk_i);
        verify_flag("lsu_ready_o", lsu_ready_o, 1'b1);
        verify_flag("load_valid_o", load_valid_o, 1'b0);
        verify_flag("store_valid_o", store_valid_o, 1'b0);
        verify_flag("ld_mem_o.req", ld_mem_o.req, 1'b0);
        verify_flag("st_mem_o.req", st_mem_o.req, 1'b0);
        verify_flag("pop_ld", UUT.pop_ld, 1'b0);
        verify_flag("pop_st", UUT.pop_st, 1'b0);

        run_lane_sweep();
        run_random(200, 1'b0);
        run_random(150, 1'b1);

        // restricted region, misaligned accesses included
        for (int r = 0; r < 4; r++) begin
            base = XLEN'($urandom_range(511));
            write_region(base, base + XLEN'($urandom_range(400, 64)));
            run_random(60, 1'b1);
        end
        write_region('0, '1);

        // long grant delays back up the buffer
        drain();
        low_before = ready_low_cycles;
        slow_mem  <= 1'b1;
        run_random(80, 1'b1);
        drain();
        slow_mem <= 1'b0;
        if (ready_low_cycles == low_before) begin
            report_failure("lsu_ready_o never fell under long grant delays");
        end

        for (int i = 0; i < 256; i++) begin
            compare_mem_word(i, mem_model.words[i], shadow[i]);
        end

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_lsu_mem.sv
`default_nettype none

module tb_lsu_mem import lsu_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     slow_i,
    input  mem_req_t ld_req_i,
    output mem_rsp_t ld_rsp_o,
    input  mem_req_t st_req_i,
    output mem_rsp_t st_rsp_o
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [XLEN-1:0] words [256];
    logic [3:0]      ld_wait_q;
    logic [3:0]      ld_delay_q;
    logic [3:0]      st_wait_q;
    logic [3:0]      st_delay_q;
    logic            ld_gnt;
    logic            st_gnt;
    logic            rvalid_q;
    logic [XLEN-1:0] rdata_q;

    function automatic logic [XLEN-1:0] fill_word(logic [7:0] idx);
        return {idx ^ 8'ha5, ~idx, idx, idx + 8'h3c};
    endfunction

    // long delays keep the bypass buffer occupied
    function automatic logic [3:0] pick_delay(logic slow);
        if (slow) begin
            return 4'(4 + $urandom_range(7));
        end
        return 4'($urandom_range(3));
    endfunction

    initial begin
        for (int i = 0; i < 256; i++) begin
            words[i] = fill_word(8'(i));
        end
    end

    assign ld_gnt = ld_req_i.req && (ld_wait_q == ld_delay_q);
    assign st_gnt = st_req_i.req && (st_wait_q == st_delay_q);

    // --------------------------------------------------
    // grant delay per port
    // --------------------------------------------------
    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ld_wait_q  <= '0;
            ld_delay_q <= '0;
            st_wait_q  <= '0;
            st_delay_q <= '0;
            rvalid_q   <= 1'b0;
        end else begin
            if (ld_gnt) begin
                ld_wait_q  <= '0;
                ld_delay_q <= pick_delay(slow_i);
            end else if (ld_req_i.req) begin
                ld_wait_q <= ld_wait_q + 4'd1;
            end
            if (st_gnt) begin
                st_wait_q  <= '0;
                st_delay_q <= pick_delay(slow_i);
            end else if (st_req_i.req) begin
                st_wait_q <= st_wait_q + 4'd1;
            end
            rvalid_q <= ld_gnt;
        end
    end

    // read captured at grant, write lands in its grant cycle
    always @(posedge clk_i) begin
        if (ld_gnt) begin
            rdata_q <= words[ld_req_i.addr[9:2]];
        end
        if (st_gnt) begin
            for (int b = 0; b < BE_W; b++) begin
                if (st_req_i.be[b]) begin
                    words[st_req_i.addr[9:2]][8*b +: 8] = st_req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    assign ld_rsp_o = '{gnt: ld_gnt, rvalid: rvalid_q, rdata: rdata_q};
    assign st_rsp_o = '{gnt: st_gnt, rvalid: 1'b0, rdata: '0};

endmodule

`default_nettype wire

//--- lsu_top.sv
`default_nettype none

module lsu_top import lsu_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    // issue
    input  logic        lsu_valid_i,
    input  lsu_req_t    lsu_req_i,
    output logic        lsu_ready_o,
    // region config
    input  region_cfg_t cfg_i,
    // memory ports
    output mem_req_t    ld_mem_o,
    input  mem_rsp_t    ld_mem_i,
    output mem_req_t    st_mem_o,
    input  mem_rsp_t    st_mem_i,
    // write-back
    output logic        load_valid_o,
    output lsu_result_t load_result_o,
    output logic        store_valid_o,
    output lsu_result_t store_result_o
);

    lsu_ctrl_t req_ctrl;
    lsu_ctrl_t lsu_ctrl;
    region_t   region;
    lsu_ex_t   ex;
    logic      pop_ld;
    logic      pop_st;

    // ------------------------------------------------
    // address generation and buffering
    // ------------------------------------------------
    lsu_agu i_agu (
        .lsu_valid_i (lsu_valid_i),
        .lsu_req_i   (lsu_req_i),
        .lsu_ctrl_o  (req_ctrl)
    );

    lsu_bypass i_bypass (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .lsu_ctrl_i  (req_ctrl),
        .lsu_valid_i (lsu_valid_i),
        .pop_ld_i    (pop_ld),
        .pop_st_i    (pop_st),
        .lsu_ctrl_o  (lsu_ctrl),
        .ready_o     (lsu_ready_o)
    );

    // ------------------------------------------------
    // fault check
    // ------------------------------------------------
    lsu_region_cfg i_region_cfg (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .cfg_i    (cfg_i),
        .region_o (region)
    );

    lsu_fault_check i_fault_check (
        .lsu_ctrl_i (lsu_ctrl),
        .region_i   (region),
        .ex_o       (ex)
    );

    // ------------------------------------------------
    // load and store units
    // ------------------------------------------------
    lsu_load_unit i_load_unit (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .lsu_ctrl_i (lsu_ctrl),
        .ex_i       (ex),
        .pop_ld_o   (pop_ld),
        .mem_req_o  (ld_mem_o),
        .mem_rsp_i  (ld_mem_i),
        .valid_o    (load_valid_o),
        .result_o   (load_result_o)
    );

    lsu_store_unit i_store_unit (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .lsu_ctrl_i (lsu_ctrl),
        .ex_i       (ex),
        .pop_st_o   (pop_st),
        .mem_req_o  (st_mem_o),
        .mem_rsp_i  (st_mem_i),
        .valid_o    (store_valid_o),
        .result_o   (store_result_o)
    );

endmodule

`default_nettype wire

//--- lsu_store_unit.sv
`default_nettype none

module lsu_store_unit import lsu_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  lsu_ctrl_t   lsu_ctrl_i,
    input  lsu_ex_t     ex_i,
    output logic        pop_st_o,
    output mem_req_t    mem_req_o,
    input  mem_rsp_t    mem_rsp_i,
    output logic        valid_o,
    output lsu_result_t result_o
);

    typedef enum logic {IDLE, WAIT_GNT} st_state_e;

    st_state_e   state_d, state_q;
    lsu_ctrl_t   ctrl_q;
    lsu_ctrl_t   cur;
    logic        head_st;
    logic        valid_d, valid_q;
    lsu_result_t result_d, result_q;

    assign head_st = lsu_ctrl_i.valid && !op_is_load(lsu_ctrl_i.op);
    assign cur     = (state_q == IDLE) ? lsu_ctrl_i : ctrl_q;

    // write port, data already in its lane
    always_comb begin
        mem_req_o.req   = (state_q == IDLE && head_st && !ex_i.valid)
                       || (state_q == WAIT_GNT);
        mem_req_o.we    = 1'b1;
        mem_req_o.addr  = {cur.vaddr[XLEN-1:2], 2'b00};
        mem_req_o.be    = cur.be;
        mem_req_o.wdata = cur.wdata;
    end

    // ------------------------------------------------
    // FSM
    // ------------------------------------------------
    always_comb begin
        state_d           = state_q;
        pop_st_o          = 1'b0;
        valid_d           = 1'b0;
        result_d          = '0;
        result_d.trans_id = cur.trans_id;
        if (state_q == IDLE && head_st && ex_i.valid) begin
            pop_st_o    = 1'b1;
            valid_d     = 1'b1;
            result_d.ex = ex_i;
        end else if (mem_req_o.req && mem_rsp_i.gnt) begin
            // write lands in the grant cycle
            pop_st_o = 1'b1;
            valid_d  = 1'b1;
            state_d  = IDLE;
        end else if (mem_req_o.req) begin
            state_d = WAIT_GNT;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            valid_q <= valid_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE) begin
            ctrl_q <= lsu_ctrl_i;
        end
        if (valid_d) begin
            result_q <= result_d;
        end
    end

    assign valid_o  = valid_q;
    assign result_o = result_q;

    // request held stable until granted
    a_hold_until_gnt: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (mem_req_o.req && !mem_rsp_i.gnt) |=>
            (mem_req_o.req && $stable(mem_req_o.addr) && $stable(mem_req_o.wdata))
    );

endmodule

`default_nettype wire

//--- lsu_load_unit.sv
`default_nettype none

module lsu_load_unit import lsu_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  lsu_ctrl_t   lsu_ctrl_i,
    input  lsu_ex_t     ex_i,
    output logic        pop_ld_o,
    output mem_req_t    mem_req_o,
    input  mem_rsp_t    mem_rsp_i,
    output logic        valid_o,
    output lsu_result_t result_o
);

    typedef enum logic [1:0] {IDLE, WAIT_GNT, WAIT_RVALID} ld_state_e;

    ld_state_e       state_d, state_q;
    lsu_ctrl_t       ctrl_q;
    lsu_ctrl_t       cur;
    logic            head_ld;
    logic [XLEN-1:0] lane;
    logic [XLEN-1:0] ld_data;
    logic            valid_d, valid_q;
    lsu_result_t     result_d, result_q;

    assign head_ld = lsu_ctrl_i.valid && op_is_load(lsu_ctrl_i.op);
    // head while idle, the load in flight afterwards
    assign cur     = (state_q == IDLE) ? lsu_ctrl_i : ctrl_q;

    // ------------------------------------------------
    // read port
    // ------------------------------------------------
    always_comb begin
        mem_req_o.req   = (state_q == IDLE && head_ld && !ex_i.valid)
                       || (state_q == WAIT_GNT);
        mem_req_o.we    = 1'b0;
        mem_req_o.addr  = {cur.vaddr[XLEN-1:2], 2'b00};
        mem_req_o.be    = cur.be;
        mem_req_o.wdata = '0;
    end

    // lane extraction and extension
    assign lane = mem_rsp_i.rdata >> {ctrl_q.vaddr[1:0], 3'b000};

    always_comb begin
        case (ctrl_q.op)
            LB:      ld_data = {{(XLEN-8){lane[7]}}, lane[7:0]};
            LBU:     ld_data = {{(XLEN-8){1'b0}}, lane[7:0]};
            LH:      ld_data = {{(XLEN-16){lane[15]}}, lane[15:0]};
            LHU:     ld_data = {{(XLEN-16){1'b0}}, lane[15:0]};
            default: ld_data = lane;
        endcase
    end

    // ------------------------------------------------
    // FSM
    // ------------------------------------------------
    always_comb begin
        state_d  = state_q;
        pop_ld_o = 1'b0;
        valid_d  = 1'b0;
        result_d = '0;
        case (state_q)
            IDLE: begin
                if (head_ld) begin
                    if (ex_i.valid) begin
                        // fault, memory stays untouched
                        pop_ld_o          = 1'b1;
                        valid_d           = 1'b1;
                        result_d.trans_id = cur.trans_id;
                        result_d.ex       = ex_i;
                    end else if (mem_rsp_i.gnt) begin
                        pop_ld_o = 1'b1;
                        state_d  = WAIT_RVALID;
                    end else begin
                        state_d = WAIT_GNT;
                    end
                end
            end
            WAIT_GNT: begin
                if (mem_rsp_i.gnt) begin
                    pop_ld_o = 1'b1;
                    state_d  = WAIT_RVALID;
                end
            end
            WAIT_RVALID: begin
                if (mem_rsp_i.rvalid) begin
                    valid_d           = 1'b1;
                    result_d.trans_id = ctrl_q.trans_id;
                    result_d.data     = ld_data;
                    state_d           = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            valid_q <= valid_d;
        end
    end

    // track the head until the load leaves idle
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE) begin
            ctrl_q <= lsu_ctrl_i;
        end
        if (valid_d) begin
            result_q <= result_d;
        end
    end

    assign valid_o  = valid_q;
    assign result_o = result_q;

    a_rvalid_expected: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        mem_rsp_i.rvalid |-> (state_q == WAIT_RVALID)
    );

endmodule

`default_nettype wire

//--- lsu_fault_check.sv
`default_nettype none

module lsu_fault_check import lsu_pkg::*; (
    input  lsu_ctrl_t lsu_ctrl_i,
    input  region_t   region_i,
    output lsu_ex_t   ex_o
);

    logic is_load;
    logic misaligned;
    logic out_of_region;

    assign is_load = op_is_load(lsu_ctrl_i.op);

    always_comb begin
        case (op_size(lsu_ctrl_i.op))
            SIZE_H:  misaligned = lsu_ctrl_i.vaddr[0];
            SIZE_W:  misaligned = (lsu_ctrl_i.vaddr[1:0] != 2'b00);
            default: misaligned = 1'b0;
        endcase
    end

    // inclusive bounds
    assign out_of_region = (lsu_ctrl_i.vaddr < region_i.base)
                        || (lsu_ctrl_i.vaddr > region_i.limit);

    // access fault takes priority over misaligned
    always_comb begin
        ex_o = '0;
        if (lsu_ctrl_i.valid) begin
            if (out_of_region) begin
                ex_o.valid = 1'b1;
                ex_o.cause = is_load ? LD_ACCESS_FAULT : ST_ACCESS_FAULT;
            end else if (misaligned) begin
                ex_o.valid = 1'b1;
                ex_o.cause = is_load ? LD_ADDR_MISALIGNED : ST_ADDR_MISALIGNED;
            end
            if (ex_o.valid) begin
                ex_o.tval = lsu_ctrl_i.vaddr;
            end
        end
    end

endmodule

`default_nettype wire

//--- lsu_region_cfg.sv
`default_nettype none

module lsu_region_cfg import lsu_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  region_cfg_t cfg_i,
    output region_t     region_o
);

    region_t region_q;

    // ------------------------------------------------
    // base and limit registers
    // ------------------------------------------------
    // whole address space allowed out of reset
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            region_q.base  <= '0;
            region_q.limit <= '1;
        end else if (cfg_i.we) begin
            if (cfg_i.sel) begin
                region_q.limit <= cfg_i.wdata;
            end else begin
                region_q.base <= cfg_i.wdata;
            end
        end
    end

    assign region_o = region_q;

endmodule

`default_nettype wire

//--- lsu_bypass.sv
`default_nettype none

module lsu_bypass import lsu_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  lsu_ctrl_t lsu_ctrl_i,
    input  logic      lsu_valid_i,
    input  logic      pop_ld_i,
    input  logic      pop_st_i,
    output lsu_ctrl_t lsu_ctrl_o,
    output logic      ready_o
);

    lsu_ctrl_t [1:0] mem_q;
    logic            rd_ptr_q;
    logic            wr_ptr_q;
    logic [1:0]      count_q;
    logic            push;
    logic            pop;
    logic            empty;

    assign empty   = (count_q == 2'd0);
    assign ready_o = empty;
    assign push    = lsu_valid_i && ready_o;
    assign pop     = pop_ld_i || pop_st_i;

    // head entry, or the incoming request when nothing is held
    assign lsu_ctrl_o = empty ? lsu_ctrl_i : mem_q[rd_ptr_q];

    // ------------------------------------------------
    // pointers and fill level
    // ------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= 1'b0;
            wr_ptr_q <= 1'b0;
            count_q  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr_q <= ~wr_ptr_q;
            end
            if (pop) begin
                rd_ptr_q <= ~rd_ptr_q;
            end
            count_q <= count_q + {1'b0, push} - {1'b0, pop};
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= lsu_ctrl_i;
        end
    end

    // issue side must respect ready
    a_no_push_when_full: assert property (
        @(posedge clk_i) disable iff (!rst_ni) lsu_valid_i |-> ready_o
    );

    // head goes to exactly one unit
    a_single_pop: assert property (
        @(posedge clk_i) disable iff (!rst_ni) !(pop_ld_i && pop_st_i)
    );

endmodule

`default_nettype wire

//--- lsu_agu.sv
`default_nettype none

module lsu_agu import lsu_pkg::*; (
    input  logic      lsu_valid_i,
    input  lsu_req_t  lsu_req_i,
    output lsu_ctrl_t lsu_ctrl_o
);

    logic [XLEN-1:0] vaddr;
    logic [BE_W-1:0] size_mask;

    // wraps around on overflow
    assign vaddr = lsu_req_i.operand_a + lsu_req_i.imm;

    always_comb begin
        case (op_size(lsu_req_i.op))
            SIZE_B:  size_mask = 4'b0001;
            SIZE_H:  size_mask = 4'b0011;
            default: size_mask = 4'b1111;
        endcase
    end

    always_comb begin
        lsu_ctrl_o.valid    = lsu_valid_i;
        lsu_ctrl_o.vaddr    = vaddr;
        // misaligned accesses keep their shifted enables
        lsu_ctrl_o.be       = size_mask << vaddr[1:0];
        // store data moved into its byte lane
        lsu_ctrl_o.wdata    = lsu_req_i.operand_b << {vaddr[1:0], 3'b000};
        lsu_ctrl_o.op       = lsu_req_i.op;
        lsu_ctrl_o.trans_id = lsu_req_i.trans_id;
    end

endmodule

`default_nettype wire

//--- lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // ------------------------------------------------
    // widths
    // ------------------------------------------------
    localparam int unsigned XLEN          = 32;
    localparam int unsigned BE_W          = 4;
    localparam int unsigned TRANS_ID_BITS = 3;

    // ------------------------------------------------
    // operations and causes
    // ------------------------------------------------
    typedef enum logic [2:0] {
        LB, LBU, LH, LHU, LW, SB, SH, SW
    } lsu_op_e;

    typedef enum logic [1:0] {
        SIZE_B, SIZE_H, SIZE_W
    } lsu_size_e;

    typedef enum logic [3:0] {
        LD_ADDR_MISALIGNED = 4'd4,
        LD_ACCESS_FAULT    = 4'd5,
        ST_ADDR_MISALIGNED = 4'd6,
        ST_ACCESS_FAULT    = 4'd7
    } lsu_cause_e;

    function automatic logic op_is_load(lsu_op_e op);
        return op inside {LB, LBU, LH, LHU, LW};
    endfunction

    function automatic lsu_size_e op_size(lsu_op_e op);
        case (op)
            LB, LBU, SB: return SIZE_B;
            LH, LHU, SH: return SIZE_H;
            default:     return SIZE_W;
        endcase
    endfunction

    // ------------------------------------------------
    // shared structs
    // ------------------------------------------------
    typedef struct packed {
        lsu_cause_e        cause;
        logic [XLEN-1:0]   tval;
        logic              valid;
    } lsu_ex_t;

    // issued request, imm already sign extended
    typedef struct packed {
        lsu_op_e                  op;
        logic [XLEN-1:0]          operand_a;
        logic [XLEN-1:0]          imm;
        logic [XLEN-1:0]          operand_b;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } lsu_req_t;

    typedef struct packed {
        logic                     valid;
        logic [XLEN-1:0]          vaddr;
        logic [XLEN-1:0]          wdata;
        logic [BE_W-1:0]          be;
        lsu_op_e                  op;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } lsu_ctrl_t;

    typedef struct packed {
        logic [TRANS_ID_BITS-1:0] trans_id;
        logic [XLEN-1:0]          data;
        lsu_ex_t                  ex;
    } lsu_result_t;

    typedef struct packed {
        logic            req;
        logic            we;
        logic [XLEN-1:0] addr;
        logic [BE_W-1:0] be;
        logic [XLEN-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic            gnt;
        logic            rvalid;
        logic [XLEN-1:0] rdata;
    } mem_rsp_t;

    // sel 0 writes base, sel 1 writes limit
    typedef struct packed {
        logic            we;
        logic            sel;
        logic [XLEN-1:0] wdata;
    } region_cfg_t;

    typedef struct packed {
        logic [XLEN-1:0] base;
        logic [XLEN-1:0] limit;
    } region_t;

endpackage

`default_nettype wire
